/* all.f */
+incdir+verilog
verilog/streamCfgPkg.sv
verilog/dataBusPkg.sv
verilog/streamAddrGen.sv
verilog/dualPortRam.sv
verilog/extWriter.sv
verilog/streamWriteTop.sv
testbench/busMemModel.sv
testbench/streamWriteTb.sv

/* testbench/busMemModel.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module busMemModel
  (
   input  logic               clk,
   input  logic               rst,
   input  logic [1:0]         readyBits,
   input  logic               busValid,
   input  dataBusPkg::busReqT busReq,
   output logic               busReady
   );

   logic [31:0]           lfsr;
   logic [1:0]            bitsNow;
   logic                  rstNow;
   logic                  readyNext;
   logic [`IO_ADDR_W-1:0] addrLog [$];
   logic [`DATA_W-1:0]    dataLog [$];
   logic [`STRB_W-1:0]    strbLog [$];

   // galois form, taps 32 30 26 25
   function automatic logic [31:0] stepLfsr(input logic [31:0] state);
      if (state[0])
      begin
         return (state >> 1) ^ 32'hA300_0000;
      end
      return state >> 1;
   endfunction

   initial
   begin
      lfsr     = 32'had48_08ba;
      busReady = 1'b0;
   end

   // n bits taken, ready when all are one, so 1 in 2**n
   always @(posedge clk)
   begin
      bitsNow = readyBits;
      rstNow  = rst;
      #1;
      readyNext = 1'b1;
      for (int k = 0; k < bitsNow; k++)
      begin
         lfsr      = stepLfsr(lfsr);
         readyNext = readyNext & lfsr[0];
      end
      busReady = readyNext && !rstNow;
   end

   // handshake seen here completes on the next rising edge
   always @(negedge clk)
   begin
      if (!rst && busValid && busReady)
      begin
         addrLog.push_back(busReq.addr);
         dataLog.push_back(busReq.wdata);
         strbLog.push_back(busReq.wstrb);
      end
   end

endmodule

`default_nettype wire

/* testbench/streamWriteTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module streamWriteTb;

   localparam int NUM_CASES = 7;
   localparam int TIMEOUT   = 4000;
   localparam int MEM_WORDS = 1 << `MEM_ADDR_W;

   typedef struct packed {
      streamCfgPkg::genCfgT gen;
      streamCfgPkg::extCfgT ext;
      logic [1:0]           readyBits;
      logic [`DATA_W-1:0]   tag;
   } testCaseT;

   logic                 clk;
   logic                 rst;
   logic                 run;
   logic                 done;
   logic [`DATA_W-1:0]   in0;
   streamCfgPkg::genCfgT genCfg;
   streamCfgPkg::extCfgT extCfg;
   logic                 busValid;
   dataBusPkg::busReqT   busReq;
   logic                 busReady;
   logic [1:0]           readyBits;

   testCaseT           cases [NUM_CASES];
   logic [`DATA_W-1:0] refMem [MEM_WORDS];
   int                 logStart [NUM_CASES];
   int                 errorCount;
   int                 checkCount;
   bit                 timedOut;
   bit                 stallSeen;
   dataBusPkg::busReqT heldReq;

   streamWriteTop UUT (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .done     (done),
      .in0      (in0),
      .genCfg   (genCfg),
      .extCfg   (extCfg),
      .busValid (busValid),
      .busReq   (busReq),
      .busReady (busReady)
   );

   busMemModel memModel (
      .clk       (clk),
      .rst       (rst),
      .readyBits (readyBits),
      .busValid  (busValid),
      .busReq    (busReq),
      .busReady  (busReady)
   );

   always #4 clk = ~clk;

   // a stalled request comes back unchanged one cycle later
   always @(negedge clk)
   begin
      if (!rst && stallSeen)
      begin
         checkValue("busValid while stalled", busValid, 1'b1);
         checkValue("busReq.addr while stalled", busReq.addr, heldReq.addr);
         checkValue("busReq.wdata while stalled", busReq.wdata, heldReq.wdata);
         checkValue("busReq.wstrb while stalled", busReq.wstrb, heldReq.wstrb);
      end
      stallSeen = !rst && busValid && !busReady;
      heldReq   = busReq;
   end

   function automatic testCaseT makeCase(input int start, iterations, period, duty,
                                         input int shift, incr, reverse,
                                         input logic [31:0] extAddr, input int intAddr,
                                         input int size, ready, input logic [31:0] tag);
      testCaseT tc;
      tc.gen.start      = start;
      tc.gen.iterations = iterations;
      tc.gen.period     = period;
      tc.gen.duty       = duty;
      tc.gen.shift      = shift;
      tc.gen.incr       = incr;
      tc.gen.reverse    = reverse;
      tc.ext.extAddr    = extAddr;
      tc.ext.intAddr    = intAddr;
      tc.ext.size       = size;
      tc.readyBits      = ready;
      tc.tag            = tag;
      return tc;
   endfunction

   // msb of the result is lsb of the input
   function automatic int mirrorAddr(input int addr);
      int res;
      res = 0;
      for (int k = 0; k < `MEM_ADDR_W; k++)
      begin
         res = (res << 1) | ((addr >> k) & 1);
      end
      return res;
   endfunction

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      checkCount++;
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAIL %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   // replay of the loop nest; cycle c carries tag + c
   task automatic applyProducer(input testCaseT tc);
      int c;
      int addr;
      c = 0;
      for (int i = 0; i < tc.gen.iterations; i++)
      begin
         for (int p = 0; p < tc.gen.period; p++)
         begin
            c++;
            if (p < tc.gen.duty)
            begin
               addr = (tc.gen.start + i * tc.gen.shift + p * tc.gen.incr) % MEM_WORDS;
               if (tc.gen.reverse)
               begin
                  addr = mirrorAddr(addr);
               end
               refMem[addr] = tc.tag + c;
            end
         end
      end
   endtask

   // in0 counts up one word per cycle while waiting
   task automatic waitForDone(input int n, output bit ok);
      int cyc;
      cyc = 0;
      while (!done && cyc < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         in0 = in0 + 1;
         cyc++;
      end
      ok = done;
      if (!ok)
      begin
         $display("case %0d: done did not rise within %0d cycles", n, TIMEOUT);
      end
   endtask

   // called as soon as done shows so the count also covers done timing
   task automatic checkFlush(input int n);
      testCaseT tc;
      int       base;
      int       idx;
      tc   = cases[n];
      base = logStart[n];
      checkValue($sformatf("case %0d write count", n), memModel.addrLog.size() - base,
                 tc.ext.size);
      for (int k = 0; k < tc.ext.size && base + k < memModel.addrLog.size(); k++)
      begin
         idx = (tc.ext.intAddr + k) % MEM_WORDS;
         checkValue($sformatf("case %0d busReq.addr[%0d]", n, k), memModel.addrLog[base + k],
                    tc.ext.extAddr + 32'(4 * k));
         checkValue($sformatf("case %0d busReq.wdata[%0d]", n, k), memModel.dataLog[base + k],
                    refMem[idx]);
         checkValue($sformatf("case %0d busReq.wstrb[%0d]", n, k), memModel.strbLog[base + k],
                    4'hf);
      end
   endtask

   task automatic runCase(input int n);
      testCaseT tc;
      bit       ok;
      tc = cases[n];
      @(posedge clk);
      #1;
      genCfg    = tc.gen;
      extCfg    = tc.ext;
      readyBits = tc.readyBits;
      in0       = tc.tag;
      run       = 1'b1;
      logStart[n] = memModel.addrLog.size();
      @(posedge clk);
      #1;
      run = 1'b0;
      in0 = tc.tag + 1;
      checkValue($sformatf("case %0d done after run", n), done, 1'b0);
      applyProducer(tc);
      waitForDone(n, ok);
      if (ok)
      begin
         checkFlush(n);
      end
      else
      begin
         timedOut = 1'b1;
      end
   endtask

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      run        = 1'b0;
      in0        = '0;
      genCfg     = '0;
      extCfg     = '0;
      readyBits  = 2'd0;
      errorCount = 0;
      checkCount = 0;
      timedOut   = 1'b0;
      for (int a = 0; a < MEM_WORDS; a++)
      begin
         refMem[a] = '0;
      end
      // linear fill, duty gating, bit reversal, stalls, wrap, empty producer
      cases[0] = makeCase(8'h10, 1, 16, 16, 0, 1, 0, 32'h1000_0000, 8'h10, 16, 0,
                          32'h1000_0000);
      cases[1] = makeCase(8'h40, 4, 6, 4, 8, 2, 0, 32'h2000_0100, 8'h40, 40, 0,
                          32'h2000_0000);
      cases[2] = makeCase(8'h00, 2, 8, 8, 8, 1, 1, 32'h3000_0000, 8'h00, 256, 0,
                          32'h3000_0000);
      cases[3] = makeCase(8'h40, 4, 6, 4, 8, 2, 0, 32'h4000_0000, 8'h40, 40, 2,
                          32'h4000_0000);
      cases[4] = makeCase(8'h40, 4, 6, 4, 8, 2, 0, 32'h4000_0000, 8'h40, 40, 0,
                          32'h4400_0000);
      cases[5] = makeCase(8'hf8, 3, 5, 3, 8'h21, 7, 0, 32'h5000_0000, 8'hf0, 48, 1,
                          32'h5000_0000);
      cases[6] = makeCase(8'h00, 0, 4, 4, 1, 1, 0, 32'h6000_0000, 8'h00, 4, 0,
                          32'h6000_0000);
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      checkValue("done", done, 1'b0);
      checkValue("busValid", busValid, 1'b0);
      checkValue("producer wrEn", UUT.producer.wrEn, 1'b0);
      checkValue("consumer state", UUT.consumer.state, dataBusPkg::IDLE);
      for (int n = 0; n < NUM_CASES && !timedOut; n++)
      begin
         runCase(n);
      end
      $display("checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timedOut);
      if (errorCount == 0 && !timedOut)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/dataBusPkg.sv */
`default_nettype none

`include "streamWrite_params.svh"

package dataBusPkg;

   // write request, held with valid until ready
   typedef struct packed {
      logic [`IO_ADDR_W-1:0] addr;
      logic [`DATA_W-1:0]    wdata;
      logic [`STRB_W-1:0]    wstrb;
   } busReqT;

   // external writer states
   typedef enum logic [2:0] {
      IDLE,
      WAIT_FILL,
      READ,
      SEND,
      FINISH
   } writerStateT;

endpackage

`default_nettype wire

/* verilog/dualPortRam.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module dualPortRam
  (
   input  logic                   clk,
   input  logic                   wrEn,
   input  logic [`MEM_ADDR_W-1:0] wrAddr,
   input  logic [`DATA_W-1:0]     wrData,
   input  logic                   rdEn,
   input  logic [`MEM_ADDR_W-1:0] rdAddr,
   output logic [`DATA_W-1:0]     rdData
   );

   logic [`DATA_W-1:0] mem [0:(1<<`MEM_ADDR_W)-1];

   // buffer comes up cleared
   initial
   begin
      for (int k = 0; k < (1<<`MEM_ADDR_W); k++)
      begin
         mem[k] = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[wrAddr] <= wrData;
      end
   end

   // read data holds until the next rdEn
   always_ff @(posedge clk)
   begin
      if (rdEn)
      begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

`default_nettype wire

/* verilog/extWriter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module extWriter
  (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   input  logic                   fillDone,
   input  streamCfgPkg::extCfgT   cfg,
   output logic                   rdEn,
   output logic [`MEM_ADDR_W-1:0] rdAddr,
   input  logic [`DATA_W-1:0]     rdData,
   output logic                   busValid,
   output dataBusPkg::busReqT     busReq,
   input  logic                   busReady,
   output logic                   flushDone
   );

   dataBusPkg::writerStateT state;
   logic [`IO_SIZE_W-1:0]   wordCnt;
   logic [`IO_ADDR_W-1:0]   extAddrReg;
   logic                    lastWord;

   assign lastWord  = (wordCnt == cfg.size - `IO_SIZE_W'd1);
   assign rdEn      = (state == dataBusPkg::READ);
   assign rdAddr    = cfg.intAddr + wordCnt[`MEM_ADDR_W-1:0];
   assign flushDone = (state == dataBusPkg::FINISH);

   // wdata taken from the ram output register, stable while in SEND
   always_comb
   begin
      busReq.addr  = extAddrReg;
      busReq.wdata = rdData;
      busReq.wstrb = '1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= dataBusPkg::IDLE;
         busValid   <= 1'b0;
         wordCnt    <= '0;
         extAddrReg <= '0;
      end
      else
      begin
         unique case (state)
            dataBusPkg::IDLE,
            dataBusPkg::FINISH:
            begin
               if (run)
               begin
                  state      <= dataBusPkg::WAIT_FILL;
                  wordCnt    <= '0;
                  extAddrReg <= cfg.extAddr;
               end
            end
            dataBusPkg::WAIT_FILL:
            begin
               // flush starts only once the producer is through
               if (fillDone)
               begin
                  if (cfg.size == '0)
                  begin
                     state <= dataBusPkg::FINISH;
                  end
                  else
                  begin
                     state <= dataBusPkg::READ;
                  end
               end
            end
            dataBusPkg::READ:
            begin
               state    <= dataBusPkg::SEND;
               busValid <= 1'b1;
            end
            dataBusPkg::SEND:
            begin
               if (busReady)
               begin
                  busValid   <= 1'b0;
                  wordCnt    <= wordCnt + `IO_SIZE_W'd1;
                  extAddrReg <= extAddrReg + `IO_ADDR_W'd4;
                  if (lastWord)
                  begin
                     state <= dataBusPkg::FINISH;
                  end
                  else
                  begin
                     state <= dataBusPkg::READ;
                  end
               end
            end
            default:
            begin
               state    <= dataBusPkg::IDLE;
               busValid <= 1'b0;
            end
         endcase
      end
   end

   // stalled request keeps valid and payload, ram included
   assert property (@(posedge clk) disable iff (rst)
                    busValid && !busReady |=> busValid && $stable(busReq))
      else $error("extWriter: request changed or dropped while stalled");

   assert property (@(posedge clk) disable iff (rst)
                    state == dataBusPkg::IDLE |-> !busValid)
      else $error("extWriter: busValid high in IDLE");

endmodule

`default_nettype wire

/* verilog/streamAddrGen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module streamAddrGen
  (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   input  streamCfgPkg::genCfgT   cfg,
   input  logic [`DATA_W-1:0]     in0,
   output logic                   wrEn,
   output logic [`MEM_ADDR_W-1:0] wrAddr,
   output logic [`DATA_W-1:0]     wrData,
   output logic                   fillDone
   );

   logic                   active;
   logic [`MEM_ADDR_W-1:0] iterCnt;
   logic [`PERIOD_W-1:0]   perCnt;
   logic [`MEM_ADDR_W-1:0] baseAddr;
   logic [`MEM_ADDR_W-1:0] offsetAddr;
   logic [`MEM_ADDR_W-1:0] linAddr;
   logic                   lastPer;
   logic                   lastIter;

   function automatic logic [`MEM_ADDR_W-1:0] reverseBits
      (input logic [`MEM_ADDR_W-1:0] word);
      logic [`MEM_ADDR_W-1:0] res;
      for (int k = 0; k < `MEM_ADDR_W; k++)
      begin
         res[k] = word[`MEM_ADDR_W-1-k];
      end
      return res;
   endfunction

   assign lastPer  = (perCnt == cfg.period - `PERIOD_W'd1);
   assign lastIter = (iterCnt == cfg.iterations - `MEM_ADDR_W'd1);

   // base tracks start + i*shift, offset tracks p*incr
   assign linAddr = baseAddr + offsetAddr;
   assign wrAddr  = cfg.reverse ? reverseBits(linAddr) : linAddr;
   assign wrEn    = active && (perCnt < cfg.duty);
   assign wrData  = in0;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active     <= 1'b0;
         fillDone   <= 1'b0;
         iterCnt    <= '0;
         perCnt     <= '0;
         baseAddr   <= '0;
         offsetAddr <= '0;
      end
      else if (run)
      begin
         iterCnt    <= '0;
         perCnt     <= '0;
         baseAddr   <= cfg.start;
         offsetAddr <= '0;
         // empty loop nest reports done right away
         if (cfg.iterations == '0 || cfg.period == '0)
         begin
            active   <= 1'b0;
            fillDone <= 1'b1;
         end
         else
         begin
            active   <= 1'b1;
            fillDone <= 1'b0;
         end
      end
      else if (active)
      begin
         if (lastPer)
         begin
            perCnt     <= '0;
            offsetAddr <= '0;
            baseAddr   <= baseAddr + cfg.shift;
            iterCnt    <= iterCnt + `MEM_ADDR_W'd1;
            if (lastIter)
            begin
               active   <= 1'b0;
               fillDone <= 1'b1;
            end
         end
         else
         begin
            perCnt     <= perCnt + `PERIOD_W'd1;
            offsetAddr <= offsetAddr + cfg.incr;
         end
      end
   end

   // fill finished means buffer is no longer touched
   assert property (@(posedge clk) disable iff (rst) fillDone |-> !wrEn)
      else $error("streamAddrGen: buffer write while fillDone is high");

endmodule

`default_nettype wire

/* verilog/streamCfgPkg.sv */
`default_nettype none

`include "streamWrite_params.svh"

package streamCfgPkg;

   // producer loop nest
   // addr = start + i*shift + p*incr, written while p < duty
   typedef struct packed {
      logic [`MEM_ADDR_W-1:0] start;
      logic [`MEM_ADDR_W-1:0] iterations;
      logic [`PERIOD_W-1:0]   period;
      logic [`PERIOD_W-1:0]   duty;
      logic [`MEM_ADDR_W-1:0] shift;
      logic [`MEM_ADDR_W-1:0] incr;
      logic                   reverse;
   } genCfgT;

   // consumer flush region
   typedef struct packed {
      logic [`IO_ADDR_W-1:0]  extAddr;
      logic [`MEM_ADDR_W-1:0] intAddr;
      logic [`IO_SIZE_W-1:0]  size;
   } extCfgT;

endpackage

`default_nettype wire

/* verilog/streamWriteTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "streamWrite_params.svh"

module streamWriteTop
  (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   output logic                 done,
   input  logic [`DATA_W-1:0]   in0,
   input  streamCfgPkg::genCfgT genCfg,
   input  streamCfgPkg::extCfgT extCfg,
   output logic                 busValid,
   output dataBusPkg::busReqT   busReq,
   input  logic                 busReady
   );

   logic                   fillDone;
   logic                   flushDone;
   logic                   wrEn;
   logic [`MEM_ADDR_W-1:0] wrAddr;
   logic [`DATA_W-1:0]     wrData;
   logic                   rdEn;
   logic [`MEM_ADDR_W-1:0] rdAddr;
   logic [`DATA_W-1:0]     rdData;

   // both sides finished
   assign done = fillDone & flushDone;

   streamAddrGen producer (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (genCfg),
      .in0      (in0),
      .wrEn     (wrEn),
      .wrAddr   (wrAddr),
      .wrData   (wrData),
      .fillDone (fillDone)
   );

   dualPortRam buffer (
      .clk    (clk),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   extWriter consumer (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .fillDone  (fillDone),
      .cfg       (extCfg),
      .rdEn      (rdEn),
      .rdAddr    (rdAddr),
      .rdData    (rdData),
      .busValid  (busValid),
      .busReq    (busReq),
      .busReady  (busReady),
      .flushDone (flushDone)
   );

endmodule

`default_nettype wire

/* verilog/streamWrite_params.svh */
`ifndef STREAM_WRITE_PARAMS_SVH
`define STREAM_WRITE_PARAMS_SVH

// stream word width
`define DATA_W 32

// internal buffer, 256 words
`define MEM_ADDR_W 8

// external byte address
`define IO_ADDR_W 32

// inner loop counter
`define PERIOD_W 8

// flush word count, one bit wider so a full buffer fits
`define IO_SIZE_W 9

// one strobe bit per byte
`define STRB_W (`DATA_W/8)

`endif
